// ==== Bender.yml ====
package:
  name: ebvc

sources:
  - source/ebvc_pkg.sv
  - source/ebvc_pc.sv
  - source/ebvc_regs.sv
  - source/ebvc_alu.sv
  - source/ebvc_mem.sv
  - source/ebvc_sequencer.sv
  - source/ebvc_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/ebvc_tb.sv

// ==== dv/ebvc_tests.svh ====
/* EBVC directed tests.
   Each task assembles a program, predicts the port values and runs it. */

	// Tables indexed X, Y, Z, A.
	opcode_t li_op[4]  = '{op_lix, op_liy, op_liz, op_lia};
	opcode_t ld_op[4]  = '{op_ldx, op_ldy, op_ldz, op_lda};
	opcode_t st_op[4]  = '{op_stx, op_sty, op_stz, op_sta};
	opcode_t out_op[4] = '{op_otx, op_oty, op_otz, op_ota};
	opcode_t add_op[3] = '{op_adx, op_ady, op_adz};
	opcode_t sub_op[3] = '{op_sux, op_suy, op_suz};
	opcode_t cp_op[3]  = '{op_cpx, op_cpy, op_cpz};
	opcode_t ta_op[3]  = '{op_tax, op_tay, op_taz};
	opcode_t at_op[3]  = '{op_txa, op_tya, op_tza};

	// Nine-bit add or subtract, carry from bit 8, then show A.
	task automatic add_sub_and_output(input bit sub, input word_t b);
		logic [8:0] r;
		r = sub ? {1'b0, m_reg[3]} - {1'b0, b} : {1'b0, m_reg[3]} + {1'b0, b};
		m_reg[3] = r[7:0];
		m_cf = r[8];
		m_zf = (r[7:0] == 8'h00);
		emit1(op_ota);
		expect_port(m_reg[3]);
	endtask

	// Jump on a flag to one of two X markers, then output X.
	task automatic branch_marker(input opcode_t jop, input bit taken);
		int    fix_taken, fix_end;
		word_t j, mark_t, mark_n;
		j = jop;
		mark_t = {j[3:0], 4'h1};
		mark_n = {j[3:0], 4'he};
		fix_taken = code.size() + 1;
		emit2(jop, 8'h00);
		emit2(op_lix, mark_n); // Fall-through path.
		emit1(op_otx);
		fix_end = code.size() + 1;
		emit2(op_jmp, 8'h00);
		code[fix_taken] = word_t'(code.size());
		emit2(op_lix, mark_t);
		emit1(op_otx);
		code[fix_end] = word_t'(code.size());
		m_reg[0] = taken ? mark_t : mark_n;
		expect_port(m_reg[0]);
	endtask

	task automatic z_step(input opcode_t op);
		emit1(op);
		case (op)
			op_inz: m_reg[2] = m_reg[2] + 8'd1;
			op_dez: m_reg[2] = m_reg[2] - 8'd1;
			default: m_reg[2] = 8'h00;
		endcase
		emit1(op_otz);
		expect_port(m_reg[2]);
	endtask

	task automatic reset_and_outputs();
		int    errs;
		word_t v;
		errs = errors;
		new_program();
		for (int r = 0; r < 4; r++) begin
			v = rand_byte();
			emit2(li_op[r], v);
			emit1(out_op[r]);
			expect_port(v);
		end
		emit1(op_clo);
		expect_port(8'h00);
		for (int r = 0; r < 4; r++) begin
			v = rand_byte();
			emit2(ld_op[r], word_t'(8'hc0 + r));
			emit1(out_op[r]);
			put_data(word_t'(8'hc0 + r), v);
			expect_port(v);
		end
		emit1(op_hlt);
		load_and_run();
		report_test("reset_and_outputs", errs);
	endtask

	task automatic arith_flags();
		int    errs;
		word_t b;
		errs = errors;
		new_program();
		m_reg[3] = rand_byte();
		emit2(op_lia, m_reg[3]);
		b = rand_byte();
		emit2(op_adi, b);
		add_sub_and_output(1'b0, b);
		b = rand_byte();
		emit2(op_sui, b);
		add_sub_and_output(1'b1, b);
		for (int r = 0; r < 3; r++) begin
			b = rand_byte();
			emit2(li_op[r], b);
			emit1(add_op[r]);
			add_sub_and_output(1'b0, b);
			b = rand_byte();
			emit2(li_op[r], b);
			emit1(sub_op[r]);
			add_sub_and_output(1'b1, b);
		end
		b = rand_byte();
		emit2(op_add, 8'hc0);
		put_data(8'hc0, b);
		add_sub_and_output(1'b0, b);
		b = rand_byte();
		emit2(op_sub, 8'hc1);
		put_data(8'hc1, b);
		add_sub_and_output(1'b1, b);
		branch_marker(op_jcs, m_cf);
		branch_marker(op_jzs, m_zf);
		emit2(op_cmi, m_reg[3]); // Equal compare sets both flags.
		m_cf = 1'b1;
		m_zf = 1'b1;
		emit1(op_cla); // A and both flags to zero.
		m_reg[3] = 8'h00;
		m_cf = 1'b0;
		m_zf = 1'b0;
		branch_marker(op_jcs, m_cf);
		branch_marker(op_jzs, m_zf);
		emit2(op_sui, 8'h01); // Borrow sets carry.
		add_sub_and_output(1'b1, 8'h01);
		branch_marker(op_jcs, m_cf);
		emit1(op_clc);
		m_cf = 1'b0;
		branch_marker(op_jcs, m_cf);
		b = rand_byte();
		emit2(op_lia, b);
		m_reg[3] = b;
		emit2(op_sui, b); // Zero result.
		add_sub_and_output(1'b1, b);
		branch_marker(op_jzs, m_zf);
		emit1(op_hlt);
		load_and_run();
		report_test("arith_flags", errs);
	endtask

	task automatic memory_round_trip();
		int    errs;
		word_t addr[4];
		errs = errors;
		new_program();
		for (int r = 0; r < 4; r++) begin
			m_reg[r] = rand_byte();
			emit2(li_op[r], m_reg[r]);
			addr[r] = word_t'(8'h80 + 16 * r) | (rand_byte() & 8'h0f);
		end
		for (int r = 0; r < 4; r++)
			emit2(st_op[r], addr[r]);
		emit2(op_lix, 8'h00);
		emit2(op_liy, 8'h00);
		emit1(op_clz);
		emit1(op_cla);
		for (int r = 0; r < 4; r++) begin
			emit1(out_op[r]);
			expect_port(8'h00);
		end
		for (int r = 0; r < 4; r++)
			emit2(ld_op[r], addr[r]);
		for (int r = 0; r < 4; r++) begin
			emit1(out_op[r]);
			expect_port(m_reg[r]);
		end
		emit1(op_hlt);
		load_and_run();
		report_test("memory_round_trip", errs);
	endtask

	task automatic compare_jumps();
		int    errs;
		word_t a, b, v1, v2;
		errs = errors;
		new_program();
		for (int k = 0; k < 5; k++) begin
			a = rand_byte();
			b = (k == 0) ? a : rand_byte(); // First pass compares equal.
			emit2(op_lia, a);
			m_reg[3] = a;
			case (k)
				0: emit2(op_cmi, b);
				1: begin
					emit2(op_cmp, 8'hd0);
					put_data(8'hd0, b);
				end
				default: begin
					emit2(li_op[k - 2], b);
					m_reg[k - 2] = b;
					emit1(cp_op[k - 2]);
				end
			endcase
			m_cf = (b >= m_reg[3]);
			m_zf = (b == m_reg[3]);
			branch_marker(op_jzc, !m_zf);
			branch_marker(op_jcc, !m_cf);
		end
		v1 = rand_byte();
		v2 = (v1 ^ 8'h55) | 8'h01;
		emit2(op_lia, v1);
		emit1(op_ota);
		expect_port(v1);
		emit2(op_lia, v2);
		emit2(op_jmp, word_t'(code.size() + 3));
		emit1(op_ota); // Jumped over.
		emit1(op_clo);
		expect_port(8'h00);
		emit1(op_hlt);
		load_and_run();
		report_test("compare_jumps", errs);
	endtask

	task automatic z_and_transfers();
		int    errs;
		word_t v;
		errs = errors;
		new_program();
		emit2(op_liz, 8'hfe);
		m_reg[2] = 8'hfe;
		z_step(op_inz);
		z_step(op_inz); // Wraps to zero.
		z_step(op_dez); // Wraps back.
		v = rand_byte();
		emit2(op_liz, v);
		m_reg[2] = v;
		z_step(op_dez);
		z_step(op_clz);
		for (int r = 0; r < 3; r++) begin
			v = rand_byte();
			emit2(op_lia, v);
			emit1(ta_op[r]);
			m_reg[r] = v;
		end
		emit1(8'h40);
		emit1(8'h5b);
		emit1(8'he0);
		emit1(op_cla);
		for (int r = 0; r < 3; r++) begin
			emit1(at_op[r]);
			emit1(op_ota);
			expect_port(m_reg[r]);
		end
		v = rand_byte();
		emit2(op_lia, v);
		emit1(8'h90);
		emit1(op_ota);
		expect_port(v);
		emit1(op_hlt);
		load_and_run();
		report_test("z_and_transfers", errs);
	endtask

	task automatic halt_restart();
		int    errs;
		word_t v, w;
		errs = errors;
		new_program();
		v = rand_byte();
		emit2(op_lia, v);
		emit1(op_ota);
		expect_port(v);
		emit1(op_hlt);
		emit1(op_clo); // Never reached.
		emit2(op_lia, ~v);
		emit1(op_ota);
		load_and_run();
		repeat (hold_cycles) begin
			@(negedge clk);
			check_word("port_a", port_a, v);
			check_bit("halted", halted, 1'b1);
		end
		new_program();
		w = rand_byte();
		emit2(op_lix, w);
		emit1(op_otx);
		expect_port(w);
		emit1(op_hlt);
		load_and_run();
		report_test("halt_restart", errs);
	endtask

// ==== dv/ebvc_tb.sv ====
/* EBVC testbench top.
   Clock, reset, program loader, LFSR stimulus, compare tasks and run summary. */
`timescale 1ns/1ps
`default_nettype none

module ebvc_tb import ebvc_pkg::*; ();

	localparam int load_max      = 160; // Upper bound on loader writes per program.
	localparam int run_bound     = 300; // Cycles from reset release to halt.
	localparam int num_programs  = 7;
	localparam int hold_cycles   = 50;  // Idle cycles watched after a halt.
	localparam int timeout_limit = num_programs * (load_max + 8 + run_bound) + hold_cycles + 100;

	logic  clk;
	logic  rst_n;
	logic  load_we;
	word_t load_addr;
	word_t load_data;
	word_t port_a;
	logic  halted;

	logic [31:0] lfsr = 32'h46f6;
	int    cycle_count = 0;
	int    errors = 0;
	int    checks = 0;
	int    tests_run = 0;
	word_t code[$];   // Program bytes from address 0.
	word_t data_a[$]; // Data byte addresses.
	word_t data_d[$];
	word_t exp_out[$]; // Expected port values with repeats merged.
	word_t seen[$];    // Port values seen with repeats merged.
	word_t exp_last;
	word_t m_reg[4];   // Model of X, Y, Z, A.
	bit    m_cf, m_zf;

	ebvc_top dut0 (
		.clk(clk), .rst_n(rst_n), .load_we(load_we), .load_addr(load_addr),
		.load_data(load_data), .port_a(port_a), .halted(halted)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk; // 100 ns period.

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1.
	function automatic bit lfsr_bit();
		bit fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic word_t rand_byte();
		word_t v;
		v = '0;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], lfsr_bit()}; // One step per bit.
		return v;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input bit got, input bit exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_state(input string name, input state_t got, input state_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic new_program();
		code.delete();
		data_a.delete();
		data_d.delete();
		exp_out.delete();
		exp_last = 8'h00; // Port value out of reset.
		m_reg = '{default: 8'h00};
		m_cf = 1'b0;
		m_zf = 1'b0;
	endtask

	task automatic emit1(input word_t b);
		code.push_back(b);
	endtask

	task automatic emit2(input opcode_t op, input word_t b);
		code.push_back(op);
		code.push_back(b);
	endtask

	task automatic put_data(input word_t a, input word_t d);
		data_a.push_back(a);
		data_d.push_back(d);
	endtask

	task automatic expect_port(input word_t v);
		if (v != exp_last)
			exp_out.push_back(v);
		exp_last = v;
	endtask

	// Load in reset, run to halt, then compare the port history.
	task automatic load_and_run();
		int    n;
		bit    done;
		word_t last;
		@(posedge clk);
		rst_n <= 1'b0;
		foreach (code[i]) begin
			@(posedge clk);
			load_we <= 1'b1;
			load_addr <= word_t'(i);
			load_data <= code[i];
		end
		foreach (data_a[i]) begin
			@(posedge clk);
			load_we <= 1'b1;
			load_addr <= data_a[i];
			load_data <= data_d[i];
		end
		@(posedge clk);
		load_we <= 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		check_word("port_a", port_a, 8'h00);
		check_bit("halted", halted, 1'b0);
		check_state("state", dut0.u_seq.state, st_fetch);
		@(posedge clk);
		rst_n <= 1'b1;
		seen.delete();
		last = 8'h00;
		n = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (port_a !== last) begin
				seen.push_back(port_a);
				last = port_a;
			end
			if (halted === 1'b1) begin
				done = 1'b1;
			end else begin
				n++;
				if (n > run_bound) begin
					errors++;
					$display("Program did not halt within %0d cycles", run_bound);
					done = 1'b1;
				end
			end
		end
		check_bit("halted", halted, 1'b1);
		checks++;
		if (seen.size() != exp_out.size()) begin
			errors++;
			$display("Port showed %0d values where %0d were expected",
				seen.size(), exp_out.size());
		end
		foreach (exp_out[i])
			if (i < seen.size())
				check_word($sformatf("port_a value %0d", i), seen[i], exp_out[i]);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errs_before);
	endtask

	`include "ebvc_tests.svh"

	initial begin
		rst_n = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		reset_and_outputs();
		arith_flags();
		memory_round_trip();
		compare_jumps();
		z_and_transfers();
		halt_restart();
		$display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
source/ebvc_pkg.sv
source/ebvc_pc.sv
source/ebvc_regs.sv
source/ebvc_alu.sv
source/ebvc_mem.sv
source/ebvc_sequencer.sv
source/ebvc_top.sv
dv/ebvc_tb.sv

// ==== source/ebvc_alu.sv ====
/* EBVC arithmetic unit.
   Result path for all operations, plus the carry and zero flag register. */
`timescale 1ns/1ps
`default_nettype none

module ebvc_alu import ebvc_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  alu_op_t alu_op,
	input  logic    use_reg,
	input  word_t   acc,
	input  word_t   reg_data,
	input  word_t   operand,
	output word_t   alu_result,
	output logic    cf,
	output logic    zf
);

	word_t      b_val;
	logic [8:0] sum_add;
	logic [8:0] sum_sub;

	assign b_val   = use_reg ? reg_data : operand; // Register or byte from memory.
	assign sum_add = {1'b0, acc} + {1'b0, b_val};
	assign sum_sub = {1'b0, acc} - {1'b0, b_val}; // Bit 8 is the borrow.

	always_comb begin
		case (alu_op)
			alu_pass_b: alu_result = b_val;
			alu_pass_a: alu_result = acc;
			alu_add:    alu_result = sum_add[7:0];
			alu_sub:    alu_result = sum_sub[7:0];
			alu_inc:    alu_result = b_val + 8'd1; // Wraps at 255.
			alu_dec:    alu_result = b_val - 8'd1; // Wraps at 0.
			default:    alu_result = '0; // Clears, compare, clc.
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cf <= 1'b0;
			zf <= 1'b0;
		end else begin
			case (alu_op)
				alu_add: begin
					cf <= sum_add[8];
					zf <= (sum_add[7:0] == 8'd0);
				end
				alu_sub: begin
					cf <= sum_sub[8];
					zf <= (sum_sub[7:0] == 8'd0);
				end
				alu_clr_all: begin
					cf <= 1'b0;
					zf <= 1'b0;
				end
				alu_cmp: begin
					cf <= (b_val >= acc); // Operand at least accumulator.
					zf <= (b_val == acc);
				end
				alu_clc: cf <= 1'b0;
				default: ; // Flags kept.
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/ebvc_mem.sv ====
/* EBVC shared program and data memory.
   256 bytes, combinational core read, loader port active only in reset. */
`timescale 1ns/1ps
`default_nettype none

module ebvc_mem import ebvc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  load_we,
	input  word_t load_addr,
	input  word_t load_data,
	input  word_t mem_addr,
	input  logic  mem_we,
	input  word_t mem_wdata,
	output word_t mem_rdata
);

	word_t mem [0:255];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			if (load_we)
				mem[load_addr] <= load_data; // Program image.
		end else if (mem_we) begin
			mem[mem_addr] <= mem_wdata; // Core store.
		end
	end

	assign mem_rdata = mem[mem_addr];

	// Loader must be idle once the core runs.
	assert property (@(posedge clk) load_we |-> !rst_n);

endmodule

`default_nettype wire

// ==== source/ebvc_pc.sv ====
/* EBVC program counter.
   Eight-bit counter with step and jump load, wrapping past 255. */
`timescale 1ns/1ps
`default_nettype none

module ebvc_pc import ebvc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  pc_inc,
	input  logic  pc_load,
	input  word_t load_value,
	output word_t pc
);

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= '0; // Programs start at address 0.
		else if (pc_load)
			pc <= load_value; // Jump target.
		else if (pc_inc)
			pc <= pc + 8'd1; // Wraps to 0.
	end

	// Step and load are exclusive strobes.
	assert property (@(posedge clk) disable iff (!rst_n)
		!(pc_inc && pc_load));

endmodule

`default_nettype wire

// ==== source/ebvc_pkg.sv ====
/* EBVC shared types.
   Data word, opcode map, sequencer states, ALU operations and register selects. */
`default_nettype none

package ebvc_pkg;

	typedef logic [7:0] word_t; // One data or address byte.

	// Opcode byte values of the instruction set.
	typedef enum logic [7:0] {
		op_nop = 8'h00, // One byte.
		op_ldx = 8'h01, op_lix = 8'h02, op_stx = 8'h03, // X register.
		op_ldy = 8'h09, op_liy = 8'h0a, op_sty = 8'h0b, // Y register.
		op_ldz = 8'h11, op_liz = 8'h12, op_stz = 8'h13, // Z register.
		op_inz = 8'h15, op_dez = 8'h16, op_clz = 8'h17, // Z step and clear.
		op_lda = 8'h19, op_lia = 8'h1a, op_sta = 8'h1b, // Accumulator.
		op_cla = 8'h1c, // Clears flags too.
		op_adx = 8'h21, op_ady = 8'h22, op_adz = 8'h23, // Add register.
		op_add = 8'h24, op_adi = 8'h25, // Add memory, immediate.
		op_sux = 8'h36, op_suy = 8'h37, op_suz = 8'h38, // Subtract register.
		op_sub = 8'h39, op_sui = 8'h3a, // Subtract memory, immediate.
		op_jmp = 8'h81, // Unconditional.
		op_jzs = 8'h82, op_jzc = 8'h83, // On zero flag.
		op_jcs = 8'h84, op_jcc = 8'h85, // On carry flag.
		op_txa = 8'ha1, op_tax = 8'ha2, // X transfers.
		op_tya = 8'ha3, op_tay = 8'ha4, // Y transfers.
		op_tza = 8'ha5, op_taz = 8'ha6, // Z transfers.
		op_cmp = 8'hc1, op_cmi = 8'hc2, // Compare memory, immediate.
		op_cpx = 8'hc3, op_cpy = 8'hc4, op_cpz = 8'hc5, // Compare register.
		op_clc = 8'hc6, // Carry only.
		op_clo = 8'hf9, // Port cleared.
		op_otx = 8'hfa, op_oty = 8'hfb, op_otz = 8'hfc, op_ota = 8'hfd, // Port writes.
		op_hlt = 8'hff  // Stops until reset.
	} opcode_t;

	typedef enum logic [2:0] {
		st_fetch   = 3'd0, // Opcode read, pc stepped.
		st_operand = 3'd1, // Second byte read.
		st_memory  = 3'd2, // Data read or store.
		st_execute = 3'd3, // Register, port and flag update.
		st_halt    = 3'd4
	} state_t;

	typedef enum logic [3:0] {
		alu_pass_b  = 4'd0, // Second operand.
		alu_pass_a  = 4'd1, // Accumulator.
		alu_add     = 4'd2, // Sets both flags.
		alu_sub     = 4'd3, // Sets both flags.
		alu_inc     = 4'd4, // Flags kept.
		alu_dec     = 4'd5, // Flags kept.
		alu_zero    = 4'd6, // Flags kept.
		alu_clr_all = 4'd7, // Zero result, flags cleared.
		alu_cmp     = 4'd8, // Flags only.
		alu_clc     = 4'd9  // Carry cleared.
	} alu_op_t;

	typedef enum logic [1:0] {
		sel_x = 2'd0,
		sel_y = 2'd1,
		sel_z = 2'd2,
		sel_a = 2'd3
	} reg_sel_t;

endpackage

`default_nettype wire

// ==== source/ebvc_regs.sv ====
/* EBVC register file.
   X, Y, Z, accumulator and output port, with a staged read port. */
`timescale 1ns/1ps
`default_nettype none

module ebvc_regs import ebvc_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_sel_t reg_sel,
	input  logic     reg_we,
	input  logic     port_we,
	input  word_t    wdata,
	output word_t    reg_data,
	output word_t    acc,
	output word_t    port_a
);

	word_t x_reg, y_reg, z_reg;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x_reg <= '0;
			y_reg <= '0;
			z_reg <= '0;
			acc <= '0;
			port_a <= '0;
		end else begin
			if (reg_we) begin
				case (reg_sel)
					sel_x: x_reg <= wdata;
					sel_y: y_reg <= wdata;
					sel_z: z_reg <= wdata;
					default: acc <= wdata;
				endcase
			end
			if (port_we)
				port_a <= wdata; // Visible one cycle after execute.
		end
	end

	/* Source is selected one cycle ahead, so an execute step can read one
	   register and write another through the same select. */
	always_ff @(posedge clk) begin
		case (reg_sel)
			sel_x: reg_data <= x_reg;
			sel_y: reg_data <= y_reg;
			sel_z: reg_data <= z_reg;
			default: reg_data <= acc;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/ebvc_sequencer.sv ====
/* EBVC instruction sequencer.
   Fetches and decodes each opcode, steps it through its states and drives all strobes. */
`timescale 1ns/1ps
`default_nettype none

module ebvc_sequencer import ebvc_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  word_t    mem_rdata,
	input  word_t    pc,
	input  logic     cf,
	input  logic     zf,
	output word_t    mem_addr,
	output logic     mem_we,
	output logic     pc_inc,
	output logic     pc_load,
	output reg_sel_t reg_sel,
	output logic     reg_we,
	output logic     port_we,
	output alu_op_t  alu_op,
	output logic     use_reg,
	output word_t    operand,
	output logic     halted
);

	state_t   state;
	opcode_t  ir;
	opcode_t  cur_op;
	word_t    opr;
	reg_sel_t fam, src_sel, dst_sel;
	alu_op_t  exec_op;
	logic     two_byte, mem_read, mem_write, jump, jump_taken;
	logic     exec_use_reg, exec_reg_we, exec_port_we, exec_halt;

	assign cur_op  = (state == st_fetch) ? opcode_t'(mem_rdata) : ir; // Decode early in fetch.
	assign operand = opr;
	assign halted  = (state == st_halt);

	// Register family of the opcode.
	always_comb begin
		case (cur_op)
			op_ldx, op_lix, op_stx, op_adx, op_sux, op_txa, op_tax, op_cpx, op_otx: fam = sel_x;
			op_ldy, op_liy, op_sty, op_ady, op_suy, op_tya, op_tay, op_cpy, op_oty: fam = sel_y;
			op_ldz, op_liz, op_stz, op_adz, op_suz, op_tza, op_taz, op_cpz, op_otz: fam = sel_z;
			default: fam = sel_a;
		endcase
	end

	always_comb begin
		two_byte = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		jump = 1'b0;
		jump_taken = 1'b0;
		src_sel = sel_a;
		dst_sel = sel_a;
		exec_op = alu_pass_a; // Harmless default, no flag change.
		exec_use_reg = 1'b0;
		exec_reg_we = 1'b0;
		exec_port_we = 1'b0;
		exec_halt = 1'b0;
		case (cur_op)
			op_ldx, op_ldy, op_ldz, op_lda, op_lix, op_liy, op_liz, op_lia: begin
				two_byte = 1'b1;
				mem_read = (cur_op == op_ldx) || (cur_op == op_ldy) ||
					(cur_op == op_ldz) || (cur_op == op_lda); // Address form.
				exec_op = alu_pass_b;
				dst_sel = fam;
				exec_reg_we = 1'b1;
			end
			op_stx, op_sty, op_stz, op_sta: begin
				two_byte = 1'b1;
				mem_write = 1'b1;
				src_sel = fam;
			end
			op_inz, op_dez: begin
				src_sel = sel_z;
				dst_sel = sel_z;
				exec_op = (cur_op == op_inz) ? alu_inc : alu_dec;
				exec_use_reg = 1'b1;
				exec_reg_we = 1'b1;
			end
			op_clz, op_cla: begin
				dst_sel = (cur_op == op_clz) ? sel_z : sel_a;
				exec_op = (cur_op == op_clz) ? alu_zero : alu_clr_all;
				exec_reg_we = 1'b1;
			end
			op_adx, op_ady, op_adz, op_sux, op_suy, op_suz: begin
				src_sel = fam;
				exec_op = (cur_op inside {op_adx, op_ady, op_adz}) ? alu_add : alu_sub;
				exec_use_reg = 1'b1;
				exec_reg_we = 1'b1; // Result to accumulator.
			end
			op_add, op_adi, op_sub, op_sui: begin
				two_byte = 1'b1;
				mem_read = (cur_op == op_add) || (cur_op == op_sub);
				exec_op = (cur_op inside {op_add, op_adi}) ? alu_add : alu_sub;
				exec_reg_we = 1'b1;
			end
			op_jmp: begin
				two_byte = 1'b1;
				jump = 1'b1;
				jump_taken = 1'b1;
			end
			op_jzs, op_jzc, op_jcs, op_jcc: begin
				two_byte = 1'b1;
				jump = 1'b1;
				case (cur_op)
					op_jzs: jump_taken = zf;
					op_jzc: jump_taken = !zf;
					op_jcs: jump_taken = cf;
					default: jump_taken = !cf;
				endcase
			end
			op_txa, op_tya, op_tza: begin
				src_sel = fam;
				exec_op = alu_pass_b;
				exec_use_reg = 1'b1;
				exec_reg_we = 1'b1;
			end
			op_tax, op_tay, op_taz: begin
				dst_sel = fam;
				exec_op = alu_pass_a;
				exec_reg_we = 1'b1;
			end
			op_cmp, op_cmi: begin
				two_byte = 1'b1;
				mem_read = (cur_op == op_cmp);
				exec_op = alu_cmp;
			end
			op_cpx, op_cpy, op_cpz: begin
				src_sel = fam;
				exec_op = alu_cmp;
				exec_use_reg = 1'b1;
			end
			op_clc: exec_op = alu_clc;
			op_clo: begin
				exec_op = alu_zero;
				exec_port_we = 1'b1;
			end
			op_otx, op_oty, op_otz, op_ota: begin
				src_sel = fam;
				exec_op = alu_pass_b;
				exec_use_reg = 1'b1;
				exec_port_we = 1'b1;
			end
			op_hlt: exec_halt = 1'b1;
			default: ; // Unkept opcodes run as nop.
		endcase
	end

	always_comb begin
		mem_addr = pc;
		mem_we = 1'b0;
		pc_inc = 1'b0;
		pc_load = 1'b0;
		reg_sel = src_sel; // Staged read port needs the source early.
		reg_we = 1'b0;
		port_we = 1'b0;
		alu_op = alu_pass_a;
		use_reg = 1'b0;
		case (state)
			st_fetch: pc_inc = 1'b1;
			st_operand: begin
				pc_load = jump && jump_taken; // Target is the byte on mem_rdata.
				pc_inc = !(jump && jump_taken);
			end
			st_memory: begin
				mem_addr = opr;
				mem_we = mem_write;
				alu_op = mem_write ? alu_pass_b : alu_pass_a;
				use_reg = mem_write; // Store data from register.
			end
			st_execute: begin
				reg_sel = dst_sel;
				alu_op = exec_op;
				use_reg = exec_use_reg;
				reg_we = exec_reg_we;
				port_we = exec_port_we;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_fetch;
			ir <= op_nop;
		end else begin
			case (state)
				st_fetch: begin
					ir <= cur_op;
					state <= two_byte ? st_operand : st_execute;
				end
				st_operand: begin
					if (jump)
						state <= st_fetch;
					else if (mem_read || mem_write)
						state <= st_memory;
					else
						state <= st_execute;
				end
				st_memory: state <= mem_write ? st_fetch : st_execute;
				st_execute: state <= exec_halt ? st_halt : st_fetch;
				st_halt: state <= st_halt; // Held until reset.
				default: state <= st_fetch;
			endcase
		end
	end

	// Operand byte, then data byte for address forms.
	always_ff @(posedge clk) begin
		if (state == st_operand || state == st_memory)
			opr <= mem_rdata;
	end

	// Second byte of every instruction moves pc exactly once.
	assert property (@(posedge clk) disable iff (!rst_n)
		state == st_operand |=>
			pc == ($past(pc_load) ? $past(mem_rdata) : $past(pc) + 8'd1));
	// A store leaves pc on the next opcode.
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_we |=> $stable(pc));

endmodule

`default_nettype wire

// ==== source/ebvc_top.sv ====
/* EBVC top level.
   Connects sequencer, program counter, registers, ALU and memory. */
`timescale 1ns/1ps
`default_nettype none

module ebvc_top import ebvc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  load_we,
	input  word_t load_addr,
	input  word_t load_data,
	output word_t port_a,
	output logic  halted
);

	word_t    mem_addr, mem_rdata, pc, operand;
	word_t    reg_data, acc, alu_result;
	logic     mem_we, pc_inc, pc_load, reg_we, port_we, use_reg, cf, zf;
	reg_sel_t reg_sel;
	alu_op_t  alu_op;

	ebvc_sequencer u_seq (
		.clk(clk), .rst_n(rst_n), .mem_rdata(mem_rdata), .pc(pc), .cf(cf), .zf(zf),
		.mem_addr(mem_addr), .mem_we(mem_we), .pc_inc(pc_inc), .pc_load(pc_load),
		.reg_sel(reg_sel), .reg_we(reg_we), .port_we(port_we), .alu_op(alu_op),
		.use_reg(use_reg), .operand(operand), .halted(halted)
	);

	ebvc_pc u_pc (
		.clk(clk), .rst_n(rst_n), .pc_inc(pc_inc), .pc_load(pc_load),
		.load_value(mem_rdata), .pc(pc) // Jump target from operand byte.
	);

	ebvc_regs u_regs (
		.clk(clk), .rst_n(rst_n), .reg_sel(reg_sel), .reg_we(reg_we), .port_we(port_we),
		.wdata(alu_result), .reg_data(reg_data), .acc(acc), .port_a(port_a)
	);

	ebvc_alu u_alu (
		.clk(clk), .rst_n(rst_n), .alu_op(alu_op), .use_reg(use_reg), .acc(acc),
		.reg_data(reg_data), .operand(operand), .alu_result(alu_result), .cf(cf), .zf(zf)
	);

	ebvc_mem u_mem (
		.clk(clk), .rst_n(rst_n), .load_we(load_we), .load_addr(load_addr),
		.load_data(load_data), .mem_addr(mem_addr), .mem_we(mem_we),
		.mem_wdata(alu_result), .mem_rdata(mem_rdata) // Store data via ALU pass.
	);

endmodule

`default_nettype wire
